//--- Makefile
VERILATOR ?= verilator
TOP       := miniCalcTb
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

//--- flist.f
logic/calcPkg.sv
logic/stackRam.sv
logic/calcAlu.sv
logic/stackCache.sv
logic/calcControl.sv
logic/miniCalcTop.sv
testbench/calcCore_chk.sv
testbench/miniCalcTb.sv

//--- logic/calcAlu.sv
`timescale 1ns/1ps

module calcAlu
    import calcPkg::*;
#(
    parameter int DataWidth = 8
) (
    input  opcodeE               Op,
    input  stackViewT            View,
    output logic [DataWidth-1:0] Sum,
    output logic                 Bad
);

    logic [2*DataWidth-1:0] product;

    // Operands are second (left) and first (right).
    assign product = View.second * View.first;

    always_comb
    begin
        case (Op)
            ADD:
            begin
                Sum = View.second + View.first;
            end
            SUB:
            begin
                Sum = View.second - View.first;
            end
            MUL:
            begin
                Sum = product[DataWidth-1:0];
            end
            default:
            begin
                Sum = '0;
            end
        endcase
    end

    // Results below zero are refused.
    assign Bad = (Op == SUB) && (View.second < View.first);

endmodule

//--- logic/calcControl.sv
`timescale 1ns/1ps

module calcControl
    import calcPkg::*;
(
    input  logic             Clk,
    input  logic             rst,
    input  logic             Req,
    input  opcodeE           Instruction,
    input  logic [7:0]       Operand,
    output logic             Ack,
    output logic [7:0]       Result,
    output calcErrorsT       Errors,
    output stackCmdE         Cmd,
    output logic [DataW-1:0] NewTop,
    output logic             Refill,
    input  stackViewT        View,
    input  logic [DataW-1:0] Sum,
    input  logic             Bad
);

    ctrlStateE  state;
    logic       accept;
    stackCmdE   cmdDec;
    logic       refillDec;
    logic       keepErr;
    calcErrorsT errDec;
    logic [7:0] resDec;

    assign accept = (state == IdleSt) && Req;
    assign Ack    = (state == AckSt);
    assign Cmd    = accept ? cmdDec : CmdNone;
    assign Refill = accept && refillDec;

    // ------------------------------------------------------------
    // Instruction decode against the current depth
    // ------------------------------------------------------------
    always_comb
    begin
        cmdDec    = CmdNone;
        refillDec = 1'b0;
        keepErr   = 1'b0;
        errDec    = '0;
        resDec    = '0;
        NewTop    = Operand;
        case (Instruction)
            NOP:
            begin
            end
            PUSH:
            begin
                if (View.size == '1)
                begin
                    errDec.overflow = 1'b1;
                end
                else
                begin
                    cmdDec = CmdPush;
                    resDec = Operand;
                end
            end
            POP:
            begin
                if (View.size == 0)
                begin
                    errDec.underflow = 1'b1;
                end
                else
                begin
                    cmdDec    = CmdPop;
                    refillDec = (View.size >= 3);
                    resDec    = View.second;
                end
            end
            COPY:
            begin
                if (View.size == 0)
                begin
                    errDec.underflow = 1'b1;
                end
                else if (View.size == '1)
                begin
                    errDec.overflow = 1'b1;
                end
                else
                begin
                    cmdDec = CmdDup;
                    resDec = View.first;
                end
            end
            SWAP:
            begin
                if (View.size < 2)
                begin
                    errDec.underflow = 1'b1;
                end
                else
                begin
                    cmdDec = CmdSwap;
                    resDec = View.second;
                end
            end
            ADD, SUB, MUL:
            begin
                if (View.size < 2)
                begin
                    errDec.underflow = 1'b1;
                end
                else if (Bad)
                begin
                    errDec.invalidArg = 1'b1;
                end
                else
                begin
                    cmdDec    = CmdReplace;
                    NewTop    = Sum;
                    refillDec = (View.size >= 3);
                    resDec    = Sum;
                end
            end
            LEN:
            begin
                keepErr = 1'b1;
                resDec  = 8'(View.size);
            end
            CLS:
            begin
                cmdDec = CmdClear;
            end
            default:
            begin
                errDec.invalidInstr = 1'b1;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Four-phase handshake
    // ------------------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state  <= IdleSt;
            Errors <= '0;
            Result <= '0;
        end
        else
        begin
            case (state)
                IdleSt:
                begin
                    if (Req)
                    begin
                        state  <= refillDec ? RefillSt : AckSt;
                        Result <= resDec;
                        if (!keepErr)
                        begin
                            Errors <= errDec;
                        end
                    end
                end
                // Second entry arrives from RAM here.
                RefillSt:
                begin
                    state <= AckSt;
                end
                AckSt:
                begin
                    if (!Req)
                    begin
                        state <= IdleSt;
                    end
                end
                default:
                begin
                    state <= IdleSt;
                end
            endcase
        end
    end

endmodule

//--- logic/calcPkg.sv
package calcPkg;

    // Field widths of the stack view. The top level must match these.
    localparam int DataW  = 8;
    localparam int DepthW = 4;

    // ------------------------------------------------------------
    // Instruction codes
    // ------------------------------------------------------------
    typedef enum logic [7:0] {
        NOP  = 8'h0F,
        PUSH = 8'h01,
        POP  = 8'h02,
        COPY = 8'h03,
        ADD  = 8'h04,
        SUB  = 8'h05,
        MUL  = 8'h06,
        SWAP = 8'h09,
        LEN  = 8'h22,
        CLS  = 8'h80
    } opcodeE;

    typedef enum logic [1:0] {
        IdleSt,
        RefillSt,
        AckSt
    } ctrlStateE;

    // Requests from the control to the stack cache.
    typedef enum logic [2:0] {
        CmdNone,
        CmdPush,
        CmdPop,
        CmdDup,
        CmdSwap,
        CmdReplace,
        CmdClear
    } stackCmdE;

    typedef struct packed {
        logic underflow;
        logic invalidArg;
        logic invalidInstr;
        logic overflow;
    } calcErrorsT;

    typedef struct packed {
        logic [DataW-1:0]  first;
        logic [DataW-1:0]  second;
        logic [DepthW-1:0] size;
    } stackViewT;

endpackage

//--- logic/miniCalcTop.sv
`timescale 1ns/1ps

module miniCalcTop
    import calcPkg::*;
#(
    parameter int DataWidth      = 8,
    parameter int StackDepthLog2 = 4
) (
    input  logic       Clk,
    input  logic       rst,
    input  logic       Req,
    input  opcodeE     Instruction,
    input  logic [7:0] Operand,
    output logic       Ack,
    output logic [7:0] Result,
    output stackViewT  Stack,
    output calcErrorsT Errors,
    output logic       OperationalError
);

    stackCmdE                  cmd;
    logic [DataWidth-1:0]      newTop;
    logic                      refill;
    stackViewT                 view;
    logic [DataWidth-1:0]      sum;
    logic                      bad;
    logic [StackDepthLog2-1:0] ramAddr;
    logic                      ramWrite;
    logic [DataWidth-1:0]      ramWrData;
    logic [DataWidth-1:0]      ramRdData;

    assign Stack            = view;
    assign OperationalError = Errors.underflow | Errors.invalidArg |
                              Errors.invalidInstr | Errors.overflow;

    calcControl i_calcControl (
        .Clk         (Clk),
        .rst         (rst),
        .Req         (Req),
        .Instruction (Instruction),
        .Operand     (Operand),
        .Ack         (Ack),
        .Result      (Result),
        .Errors      (Errors),
        .Cmd         (cmd),
        .NewTop      (newTop),
        .Refill      (refill),
        .View        (view),
        .Sum         (sum),
        .Bad         (bad)
    );

    stackCache #(
        .DataWidth      (DataWidth),
        .StackDepthLog2 (StackDepthLog2)
    ) i_stackCache (
        .Clk    (Clk),
        .rst    (rst),
        .Cmd    (cmd),
        .NewTop (newTop),
        .Refill (refill),
        .View   (view),
        .RdData (ramRdData),
        .Addr   (ramAddr),
        .Write  (ramWrite),
        .WrData (ramWrData)
    );

    stackRam #(
        .DataWidth      (DataWidth),
        .StackDepthLog2 (StackDepthLog2)
    ) i_stackRam (
        .Clk    (Clk),
        .Addr   (ramAddr),
        .Write  (ramWrite),
        .WrData (ramWrData),
        .RdData (ramRdData)
    );

    calcAlu #(
        .DataWidth (DataWidth)
    ) i_calcAlu (
        .Op   (Instruction),
        .View (view),
        .Sum  (sum),
        .Bad  (bad)
    );

endmodule

//--- logic/stackCache.sv
`timescale 1ns/1ps

module stackCache
    import calcPkg::*;
#(
    parameter int DataWidth      = 8,
    parameter int StackDepthLog2 = 4
) (
    input  logic                      Clk,
    input  logic                      rst,
    input  stackCmdE                  Cmd,
    input  logic [DataWidth-1:0]      NewTop,
    input  logic                      Refill,
    output stackViewT                 View,
    input  logic [DataWidth-1:0]      RdData,
    output logic [StackDepthLog2-1:0] Addr,
    output logic                      Write,
    output logic [DataWidth-1:0]      WrData
);

    stackViewT viewQ;
    logic      refillQ;
    logic      shrink;

    assign View = viewQ;

    // ------------------------------------------------------------
    // RAM side
    // ------------------------------------------------------------

    // Spill the old second when the stack grows past two.
    assign Write  = ((Cmd == CmdPush) || (Cmd == CmdDup)) && (viewQ.size >= 2);
    assign WrData = viewQ.second;
    assign shrink = (Cmd == CmdPop) || (Cmd == CmdReplace);

    // Spill goes to size-2, refill reads size-3.
    always_comb
    begin
        if (Write)
        begin
            Addr = viewQ.size - StackDepthLog2'(2);
        end
        else
        begin
            Addr = viewQ.size - StackDepthLog2'(3);
        end
    end

    // ------------------------------------------------------------
    // Top two entries and depth
    // ------------------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            viewQ   <= '0;
            refillQ <= 1'b0;
        end
        else
        begin
            refillQ <= Refill && shrink;
            if (refillQ)
            begin
                viewQ.second <= RdData;
            end
            case (Cmd)
                CmdPush:
                begin
                    viewQ.first  <= NewTop;
                    viewQ.second <= viewQ.first;
                    viewQ.size   <= viewQ.size + 1'b1;
                end
                CmdDup:
                begin
                    viewQ.second <= viewQ.first;
                    viewQ.size   <= viewQ.size + 1'b1;
                end
                CmdPop:
                begin
                    viewQ.first  <= viewQ.second;
                    viewQ.second <= '0;
                    viewQ.size   <= viewQ.size - 1'b1;
                end
                CmdSwap:
                begin
                    viewQ.first  <= viewQ.second;
                    viewQ.second <= viewQ.first;
                end
                CmdReplace:
                begin
                    viewQ.first  <= NewTop;
                    viewQ.second <= '0;
                    viewQ.size   <= viewQ.size - 1'b1;
                end
                CmdClear:
                begin
                    viewQ <= '0;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

//--- logic/stackRam.sv
`timescale 1ns/1ps

module stackRam #(
    parameter int DataWidth      = 8,
    parameter int StackDepthLog2 = 4
) (
    input  logic                      Clk,
    input  logic [StackDepthLog2-1:0] Addr,
    input  logic                      Write,
    input  logic [DataWidth-1:0]      WrData,
    output logic [DataWidth-1:0]      RdData
);

    logic [DataWidth-1:0] mem [2**StackDepthLog2];

    // Registered read, old data on a write cycle.
    always_ff @(posedge Clk)
    begin
        if (Write)
        begin
            mem[Addr] <= WrData;
        end
        RdData <= mem[Addr];
    end

endmodule

//--- testbench/calcCore_chk.sv
`timescale 1ns/1ps

module calcCore_chk
    import calcPkg::*;
(
    input logic      Clk,
    input logic      rst,
    input logic      Req,
    input logic      Ack,
    input stackCmdE  Cmd,
    input stackViewT View
);

    localparam logic [DepthW-1:0] MaxDepth = DepthW'(15);

    // Set by any failing assertion below.
    logic failSeen = 1'b0;

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------

    // Ack drops only once the host has let go of Req.
    ackAfterReq: assert property (@(posedge Clk) disable iff (rst)
        ($fell(Ack) && !$past(rst)) |-> !$past(Req))
        else
        begin
            $error("Ack fell while Req was still high");
            failSeen = 1'b1;
        end

    ackLowAfterReset: assert property (@(posedge Clk) rst |=> !Ack)
        else
        begin
            $error("Ack was high in the cycle after reset");
            failSeen = 1'b1;
        end

    // ------------------------------------------------------------
    // Depth
    // ------------------------------------------------------------

    // A full stack must never be asked to grow.
    depthLimit: assert property (@(posedge Clk) disable iff (rst)
        (View.size == MaxDepth) |-> !(Cmd inside {CmdPush, CmdDup}))
        else
        begin
            $error("Stack depth went past its maximum");
            failSeen = 1'b1;
        end

endmodule

bind calcControl calcCore_chk i_calcCore_chk (
    .Clk  (Clk),
    .rst  (rst),
    .Req  (Req),
    .Ack  (Ack),
    .Cmd  (Cmd),
    .View (View)
);

//--- testbench/miniCalcTb.sv
`timescale 1ns/1ps

module miniCalcTb
    import calcPkg::*;
();

    localparam int ClkPeriod  = 40;
    localparam int NumInstr   = 600;
    localparam int MaxDepth   = 15;
    localparam int AckLimit   = 8;
    localparam int WatchdogNs = NumInstr * 4 * ClkPeriod + 50 * ClkPeriod;

    logic       Clk;
    logic       rst;
    logic       Req;
    opcodeE     Instruction;
    logic [7:0] Operand;
    logic       Ack;
    logic [7:0] Result;
    stackViewT  Stack;
    calcErrorsT Errors;
    logic       OperationalError;

    logic [31:0] lcgState;
    logic [7:0]  model [$];
    calcErrorsT  expErr;
    logic [7:0]  expRes;
    int          expLat;

    miniCalcTop #(
        .DataWidth      (DataW),
        .StackDepthLog2 (DepthW)
    ) i_miniCalcTop (
        .Clk              (Clk),
        .rst              (rst),
        .Req              (Req),
        .Instruction      (Instruction),
        .Operand          (Operand),
        .Ack              (Ack),
        .Result           (Result),
        .Stack            (Stack),
        .Errors           (Errors),
        .OperationalError (OperationalError)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic stopRun();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped after a failure.");
    endtask

    task automatic compareValue(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            stopRun();
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Heavy on PUSH so that deep stacks and overflow get reached.
    function automatic opcodeE pickOpcode(input logic [31:0] r);
        logic [5:0] sel;
        sel = r[21:16];
        if (sel < 28) return PUSH;
        else if (sel < 32) return POP;
        else if (sel < 36) return COPY;
        else if (sel < 40) return SWAP;
        else if (sel < 45) return ADD;
        else if (sel < 50) return SUB;
        else if (sel < 55) return MUL;
        else if (sel < 58) return LEN;
        else if (sel < 60) return NOP;
        else if (sel < 61) return CLS;
        else return opcodeE'({2'b01, r[5:0]});
    endfunction

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    task automatic runModel(input opcodeE op, input logic [7:0] opnd);
        int         n;
        logic [7:0] top;
        logic [7:0] nxt;
        logic [7:0] res;
        n      = model.size();
        top    = (n >= 1) ? model[n-1] : 8'h00;
        nxt    = (n >= 2) ? model[n-2] : 8'h00;
        expRes = 8'h00;
        expLat = 1;
        if (op != LEN)
            expErr = '0;
        case (op)
            PUSH:
            begin
                if (n == MaxDepth)
                    expErr.overflow = 1'b1;
                else
                begin
                    model.push_back(opnd);
                    expRes = opnd;
                end
            end
            POP:
            begin
                if (n == 0)
                    expErr.underflow = 1'b1;
                else
                begin
                    void'(model.pop_back());
                    expRes = nxt;
                    expLat = (n >= 3) ? 2 : 1;
                end
            end
            COPY:
            begin
                if (n == 0)
                    expErr.underflow = 1'b1;
                else if (n == MaxDepth)
                    expErr.overflow = 1'b1;
                else
                begin
                    model.push_back(top);
                    expRes = top;
                end
            end
            SWAP:
            begin
                if (n < 2)
                    expErr.underflow = 1'b1;
                else
                begin
                    model[n-1] = nxt;
                    model[n-2] = top;
                    expRes     = nxt;
                end
            end
            ADD, SUB, MUL:
            begin
                if (n < 2)
                    expErr.underflow = 1'b1;
                else if (op == SUB && nxt < top)
                    expErr.invalidArg = 1'b1;
                else
                begin
                    // Results wrap to eight bits.
                    res = (op == ADD) ? nxt + top : (op == SUB) ? nxt - top : nxt * top;
                    void'(model.pop_back());
                    model[n-2] = res;
                    expRes     = res;
                    expLat     = (n >= 3) ? 2 : 1;
                end
            end
            LEN:     expRes = 8'(n);
            CLS:     model.delete();
            NOP:     expRes = 8'h00;
            default: expErr.invalidInstr = 1'b1;
        endcase
    endtask

    task automatic checkOutputs();
        int n;
        n = model.size();
        compareValue("Stack.first", Stack.first, (n >= 1) ? model[n-1] : 8'h00);
        compareValue("Stack.second", Stack.second, (n >= 2) ? model[n-2] : 8'h00);
        compareValue("Stack.size", 8'(Stack.size), 8'(n));
        compareValue("Errors", 8'(Errors), 8'(expErr));
        compareValue("Result", Result, expRes);
        compareValue("OperationalError", 8'(OperationalError), 8'(|expErr));
    endtask

    // ------------------------------------------------------------
    // Four-phase handshake, entered 2 ns after a rising edge
    // ------------------------------------------------------------
    task automatic runInstr(input opcodeE op, input logic [7:0] opnd);
        int cycles;
        Instruction = op;
        Operand     = opnd;
        Req         = 1'b1;
        runModel(op, opnd);
        cycles = 0;
        do
        begin
            @(posedge Clk);
            #1;
            cycles++;
            if (cycles > AckLimit)
            begin
                $display("Ack never came for opcode %h within %0d cycles", op, AckLimit);
                stopRun();
            end
        end
        while (!Ack);
        compareValue("Ack latency", 8'(cycles), 8'(expLat));
        checkOutputs();
        #1;
        Req = 1'b0;
        @(posedge Clk);
        #1;
        compareValue("Ack", 8'(Ack), 8'h00);
        #1;
    endtask

    initial
    begin
        #(WatchdogNs);
        $display("Watchdog expired before all instructions finished");
        stopRun();
    end

    initial
    begin
        logic [31:0] r;
        int          i;
        Clk         = 1'b0;
        rst         = 1'b1;
        Req         = 1'b0;
        Instruction = NOP;
        Operand     = 8'h00;
        lcgState    = 32'h9ed2_0f4b;
        expErr      = '0;
        expRes      = 8'h00;
        repeat (2) @(posedge Clk);
        #2;
        rst = 1'b0;
        compareValue("Ack", 8'(Ack), 8'h00);
        checkOutputs();
        for (i = 0; i < NumInstr; i++)
        begin
            r = nextRand();
            runInstr(pickOpcode(r), r[31:24]);
        end
        if (i_miniCalcTop.i_calcControl.i_calcCore_chk.failSeen)
        begin
            $display("A bound assertion on the handshake or the depth failed");
            stopRun();
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
